// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= vdc_timing_tb
FILELIST  ?= files.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) hdl/vdc_macros.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+hdl
hdl/vdc_pkg.sv
hdl/vdc_reg_decode.sv
hdl/vdc_signals_h.sv
hdl/vdc_signals_v.sv
hdl/vdc_fetch_issue.sv
hdl/vdc_timing_top.sv
sim/vdc_timing_properties.sv
sim/vdc_timing_tb.sv

// ==== hdl/vdc_fetch_issue.sv ====
`timescale 1ns/1ps
`include "vdc_macros.svh"

module vdc_fetch_issue import vdc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       fetch_frame,
	input  logic       fetch_row,
	input  logic       fetch_line,
	input  logic [7:0] row,
	input  logic [4:0] line,
	input  logic       credit_ret,
	output logic       req_valid,
	output fetch_req_t req,
	output logic       overflow // sticky, a request was lost
);

	localparam int CW = $clog2(`VDC_FETCH_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          slot_valid;
	fetch_req_t    slot_req;
	fetch_req_t    new_req;
	logic          new_any;
	logic          issue;

	assign new_any = fetch_frame | fetch_row | fetch_line;
	assign issue = (credits != '0) && (slot_valid || new_any);

	always_comb begin
		new_req.row = row;
		new_req.line = line;
		if (fetch_frame)
			new_req.kind = FETCH_FRAME;
		else if (fetch_row)
			new_req.kind = FETCH_ROW;
		else
			new_req.kind = FETCH_LINE;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CW'(`VDC_FETCH_CREDITS);
			slot_valid <= 1'b0;
			req_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			req_valid <= issue;
			if (issue)
				req <= slot_valid ? slot_req : new_req; // held request goes first
			if (new_any && (slot_valid || !issue))
				slot_req <= new_req;
			if (new_any && slot_valid && !issue)
				overflow <= 1'b1;
			slot_valid <= (slot_valid && !issue) || (new_any && (slot_valid || !issue));
			if (issue && !credit_ret)
				credits <= credits - 1'b1;
			else if (!issue && credit_ret)
				credits <= credits + 1'b1;
		end
	end

endmodule

// ==== hdl/vdc_macros.svh ====
`ifndef VDC_MACROS_SVH
`define VDC_MACROS_SVH

// vertical blanking geometry in lines, relative to the next vsync
`define VDC_VB_FRONT_PORCH 3
`define VDC_VB_WIDTH 24

// requests the fetcher accepts before it must hand back a credit
`define VDC_FETCH_CREDITS 2

// register reset values, PAL screen
`define VDC_RST_HT 8'd126 // horizontal total (minus 1)
`define VDC_RST_HD 8'd80 // horizontal displayed
`define VDC_RST_HP 8'd102 // hsync position
`define VDC_RST_HW 4'd9 // hsync width in characters
`define VDC_RST_VT 8'd39 // vertical total (minus 1)
`define VDC_RST_VD 8'd25 // vertical displayed rows
`define VDC_RST_VP 8'd32 // vsync position (plus 1)
`define VDC_RST_VW 4'd4 // vsync width in lines
`define VDC_RST_CTV 5'd7 // character height (minus 1)

`endif

// ==== hdl/vdc_pkg.sv ====
package vdc_pkg;

	// register fields used by the timing blocks
	typedef struct packed {
		logic [7:0] ht; // R0 horizontal total
		logic [7:0] hd; // R1 horizontal displayed
		logic [7:0] hp; // R2 hsync position
		logic [3:0] hw; // R3[3:0] hsync width
		logic [3:0] vw; // R3[7:4] vsync width
		logic [7:0] vt; // R4 vertical total
		logic [7:0] vd; // R6 vertical displayed
		logic [7:0] vp; // R7 vsync position
		logic [4:0] va; // R5 vertical total adjust
		logic [1:0] im; // R8 interlace mode
		logic [4:0] ctv; // R9 character total vertical
		logic [4:0] vss; // R24[4:0] vertical smooth scroll
	} vdc_regs_t;

	// R3 carries both sync widths in one byte
	typedef struct packed {
		logic [3:0] vw;
		logic [3:0] hw;
	} vdc_sync_width_t;

	typedef union packed {
		logic [7:0]      raw;
		vdc_sync_width_t width;
	} vdc_reg_data_u;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic vblank;
		logic display; // both h and v inside the visible area
		logic frame; // field bit
	} vdc_timing_t;

	typedef enum logic [1:0] {
		FETCH_FRAME,
		FETCH_ROW,
		FETCH_LINE
	} fetch_kind_e;

	typedef struct packed {
		fetch_kind_e kind;
		logic [7:0]  row;
		logic [4:0]  line;
	} fetch_req_t;

endpackage

// ==== hdl/vdc_reg_decode.sv ====
`timescale 1ns/1ps
`include "vdc_macros.svh"

module vdc_reg_decode import vdc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       reg_we,
	input  logic [5:0] reg_addr,
	input  logic [7:0] reg_wdata,
	output vdc_regs_t  regs,
	output logic [7:0] reg_rdata
);

	vdc_reg_data_u wr_u; // write data seen through the R3 view
	vdc_reg_data_u rd_u; // R3 readback image

	assign wr_u.raw = reg_wdata;
	assign rd_u.width = '{vw: regs.vw, hw: regs.hw};

	always_ff @(posedge clk) begin
		if (reset) begin
			regs.ht <= `VDC_RST_HT;
			regs.hd <= `VDC_RST_HD;
			regs.hp <= `VDC_RST_HP;
			regs.hw <= `VDC_RST_HW;
			regs.vw <= `VDC_RST_VW;
			regs.vt <= `VDC_RST_VT;
			regs.vd <= `VDC_RST_VD;
			regs.vp <= `VDC_RST_VP;
			regs.va <= 5'd0;
			regs.im <= 2'd0;
			regs.ctv <= `VDC_RST_CTV;
			regs.vss <= 5'd0;
		end else if (reg_we) begin
			case (reg_addr)
				6'd0: regs.ht <= reg_wdata;
				6'd1: regs.hd <= reg_wdata;
				6'd2: regs.hp <= reg_wdata;
				6'd3: begin
					regs.hw <= wr_u.width.hw;
					regs.vw <= wr_u.width.vw;
				end
				6'd4: regs.vt <= reg_wdata;
				6'd5: regs.va <= reg_wdata[4:0];
				6'd6: regs.vd <= reg_wdata;
				6'd7: regs.vp <= reg_wdata;
				6'd8: regs.im <= reg_wdata[1:0];
				6'd9: regs.ctv <= reg_wdata[4:0];
				6'd24: regs.vss <= reg_wdata[4:0];
				default: ; // unmapped, write ignored
			endcase
		end
	end

	// readback, unused bits read as zero
	always_comb begin
		case (reg_addr)
			6'd0: reg_rdata = regs.ht;
			6'd1: reg_rdata = regs.hd;
			6'd2: reg_rdata = regs.hp;
			6'd3: reg_rdata = rd_u.raw;
			6'd4: reg_rdata = regs.vt;
			6'd5: reg_rdata = {3'd0, regs.va};
			6'd6: reg_rdata = regs.vd;
			6'd7: reg_rdata = regs.vp;
			6'd8: reg_rdata = {6'd0, regs.im};
			6'd9: reg_rdata = {3'd0, regs.ctv};
			6'd24: reg_rdata = {3'd0, regs.vss};
			default: reg_rdata = 8'd0;
		endcase
	end

endmodule

// ==== hdl/vdc_signals_h.sv ====
`timescale 1ns/1ps

module vdc_signals_h import vdc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      enable,
	input  vdc_regs_t regs,
	output logic      line_start,
	output logic      display_start,
	output logic      half1_end,
	output logic      hsync_start,
	output logic      line_end,
	output logic      hsync,
	output logic      h_visible
);

	logic [7:0] hcount; // character position in the line
	logic       running; // first enabled cycle after reset only primes the counter
	logic       tick;
	logic [7:0] half_pos;
	logic [4:0] hs_count; // remaining hsync characters

	assign tick = enable & running;
	assign half_pos = 8'((9'(regs.ht) + 9'd1) >> 1);

	// event decode, one enabled cycle each
	assign line_start = tick && (hcount == 8'd0);
	assign display_start = tick && (hcount == 8'd1);
	assign half1_end = tick && (hcount == half_pos);
	assign hsync_start = tick && (hcount == regs.hp);
	assign line_end = tick && (hcount == regs.ht);

	assign h_visible = running && (hcount != 8'd0) && (hcount <= regs.hd);
	assign hsync = |hs_count;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			hcount <= 8'd0;
		end else if (enable) begin
			running <= 1'b1;
			if (running) begin
				// >= also recovers when ht is lowered mid-line
				if (hcount >= regs.ht)
					hcount <= 8'd0;
				else
					hcount <= hcount + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hs_count <= 5'd0;
		end else if (hsync_start) begin
			hs_count <= {~|regs.hw, regs.hw}; // width 0 means 16
		end else if (enable && |hs_count) begin
			hs_count <= hs_count - 5'd1;
		end
	end

endmodule

// ==== hdl/vdc_signals_v.sv ====
`timescale 1ns/1ps
`include "vdc_macros.svh"

module vdc_signals_v import vdc_pkg::*; #(
	parameter int VB_FRONT_PORCH = `VDC_VB_FRONT_PORCH,
	parameter int VB_WIDTH = `VDC_VB_WIDTH
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       enable,
	input  vdc_regs_t  regs,
	input  logic       line_start,
	input  logic       display_start,
	input  logic       half1_end,
	input  logic       hsync_start,
	input  logic       line_end,
	output logic       fetch_frame, // new frame
	output logic       fetch_row, // new visible row
	output logic       fetch_line, // new visible line
	output logic [7:0] row,
	output logic [4:0] line,
	output logic       v_visible,
	output logic       vsync,
	output logic       vblank,
	output logic       frame // field, 0 = first
);

	localparam int VBW = $clog2(VB_WIDTH + 1);

	logic [7:0]     nrow; // row of the line in progress
	logic [4:0]     nsline; // scanline within the row
	logic [4:0]     ncline; // scanline with smooth scroll applied
	logic [4:0]     cline;
	logic           ilmode; // interlace sync+video, latched per frame
	logic           cframe;
	logic           vs_start;
	logic           frame_done;
	logic           sline_wrap;
	logic [7:0]     next_row;
	logic [4:0]     vs_count;
	logic [9:0]     vs_cnt; // lines since last vsync start
	logic [9:0]     vb_start [2]; // lines left before vsync, per field
	logic           frame_n;
	logic [VBW-1:0] vb_count;

	// in interlace mode the low bit follows the field and the scroll offset
	function automatic logic [4:0] correct_line(
		input logic       il,
		input logic       cf,
		input logic [4:0] vss,
		input logic [4:0] ln
	);
		return {ln[4:1], il ? (cf ^ vss[0]) : ln[0]};
	endfunction

	assign sline_wrap = nsline == correct_line(ilmode, cframe, 5'd0, regs.ctv);
	assign next_row = sline_wrap ? nrow + 8'd1 : nrow;
	assign frame_done = |regs.va
		? (nrow == regs.vt + 8'd1
			&& nsline == correct_line(ilmode, cframe, 5'd0, regs.va - 5'd1))
		: (nrow == regs.vt && sline_wrap);

	always_ff @(posedge clk) begin
		fetch_frame <= 1'b0;
		fetch_row <= 1'b0;
		fetch_line <= 1'b0;
		if (reset) begin
			nrow <= 8'd0;
			nsline <= 5'd0;
			ncline <= regs.vss;
			cline <= regs.vss;
			row <= 8'd0;
			line <= regs.vss;
			ilmode <= &regs.im;
			cframe <= 1'b0;
			vs_start <= 1'b0;
			v_visible <= 1'b0;
		end else if (enable) begin
			if (line_start) begin
				vs_start <= 1'b0;
				if (frame_done) begin
					ilmode <= &regs.im;
					cframe <= &regs.im & frame;
					nsline <= (&regs.im & frame) ? 5'd1 : 5'd0;
					if (&regs.im & frame)
						ncline <= (regs.vss == regs.ctv) ? 5'd0 : regs.vss + 5'd1;
					else
						ncline <= regs.vss;
					nrow <= 8'd0;
					vs_start <= regs.vp == 8'd0;
					fetch_frame <= regs.vd == nrow;
					fetch_row <= regs.vd != 8'd0;
					fetch_line <= regs.vd != 8'd0;
				end else begin
					if (ncline == correct_line(ilmode, cframe, regs.vss, regs.ctv)) begin
						ncline <= correct_line(ilmode, cframe, regs.vss, 5'd0);
						fetch_row <= nrow < regs.vd;
					end else begin
						ncline <= ncline + (ilmode ? 5'd2 : 5'd1);
					end
					if (sline_wrap) begin
						nsline <= cframe ? 5'd1 : 5'd0;
						nrow <= next_row;
						vs_start <= |regs.vp && (regs.vp - 8'd1 == next_row);
						fetch_frame <= regs.vd == nrow;
					end else begin
						nsline <= nsline + (ilmode ? 5'd2 : 5'd1);
					end
					fetch_line <= next_row < regs.vd;
				end
			end
			if (display_start) begin
				row <= nrow;
				cline <= ncline;
				v_visible <= nrow < regs.vd;
			end
			if (line_end)
				line <= cline;
		end
	end

	// vsync width, counts half lines while interlaced
	assign vsync = |vs_count;

	always_ff @(posedge clk) begin
		if (reset) begin
			vs_count <= 5'd0;
		end else if (enable) begin
			if (|vs_count && (line_end || (regs.im[0] && half1_end)))
				vs_count <= vs_count - 5'd1;
			else if (vs_start && (frame ? half1_end : line_end))
				vs_count <= {~|regs.vw, regs.vw}; // 0 means 16
		end
	end

	// vblank is placed from the sync position measured in the last field
	always_ff @(posedge clk) begin
		if (reset) begin
			vs_cnt <= '1;
			vb_start <= '{default: '1};
			frame_n <= 1'b0;
			frame <= 1'b0;
			vblank <= 1'b0;
			vb_count <= '0;
		end else if (enable) begin
			if (line_start) begin
				if (vs_start) begin
					vb_start[frame_n] <= vs_cnt;
					vs_cnt <= 10'd0;
					frame_n <= ~frame_n & regs.im[0];
				end else if (&vs_cnt) begin
					vb_start <= '{default: '1}; // no sync seen yet
				end else begin
					vs_cnt <= vs_cnt + 10'd1;
					vb_start[frame_n] <= vb_start[frame_n] - 10'd1;
				end
				if (vb_start[frame_n] == 10'(VB_FRONT_PORCH + 1))
					vb_count <= VBW'(VB_WIDTH);
				else if (|vb_count)
					vb_count <= vb_count - 1'b1;
			end
			if (hsync_start) begin
				vblank <= |vb_count;
				if (vb_start[frame_n] == 10'(VB_FRONT_PORCH))
					frame <= frame_n;
			end
		end
	end

endmodule

// ==== hdl/vdc_timing_top.sv ====
`timescale 1ns/1ps

module vdc_timing_top import vdc_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        enable,
	input  logic        reg_we,
	input  logic [5:0]  reg_addr,
	input  logic [7:0]  reg_wdata,
	input  logic        credit_ret,
	output logic [7:0]  reg_rdata,
	output vdc_timing_t timing,
	output logic        req_valid,
	output fetch_req_t  req,
	output logic        overflow
);

	vdc_regs_t  regs;
	logic       line_start;
	logic       display_start;
	logic       half1_end;
	logic       hsync_start;
	logic       line_end;
	logic       h_visible;
	logic       v_visible;
	logic       fetch_frame;
	logic       fetch_row;
	logic       fetch_line;
	logic [7:0] row;
	logic [4:0] line;

	assign timing.display = h_visible & v_visible;

	vdc_reg_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.regs      (regs),
		.reg_rdata (reg_rdata)
	);

	vdc_signals_h u_signals_h (
		.clk           (clk),
		.reset         (reset),
		.enable        (enable),
		.regs          (regs),
		.line_start    (line_start),
		.display_start (display_start),
		.half1_end     (half1_end),
		.hsync_start   (hsync_start),
		.line_end      (line_end),
		.hsync         (timing.hsync),
		.h_visible     (h_visible)
	);

	vdc_signals_v u_signals_v (
		.clk           (clk),
		.reset         (reset),
		.enable        (enable),
		.regs          (regs),
		.line_start    (line_start),
		.display_start (display_start),
		.half1_end     (half1_end),
		.hsync_start   (hsync_start),
		.line_end      (line_end),
		.fetch_frame   (fetch_frame),
		.fetch_row     (fetch_row),
		.fetch_line    (fetch_line),
		.row           (row),
		.line          (line),
		.v_visible     (v_visible),
		.vsync         (timing.vsync),
		.vblank        (timing.vblank),
		.frame         (timing.frame)
	);

	vdc_fetch_issue u_fetch_issue (
		.clk         (clk),
		.reset       (reset),
		.fetch_frame (fetch_frame),
		.fetch_row   (fetch_row),
		.fetch_line  (fetch_line),
		.row         (row),
		.line        (line),
		.credit_ret  (credit_ret),
		.req_valid   (req_valid),
		.req         (req),
		.overflow    (overflow)
	);

endmodule

// ==== sim/vdc_timing_properties.sv ====
`timescale 1ns/1ps
`include "vdc_macros.svh"

module vdc_timing_properties import vdc_pkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        credit_ret,
	input vdc_timing_t timing,
	input logic        req_valid,
	input logic        overflow
);

	logic [3:0] outstanding; // requests seen on the port minus credits returned

	always_ff @(posedge clk) begin
		if (reset)
			outstanding <= 4'd0;
		else
			outstanding <= outstanding + 4'(req_valid) - 4'(credit_ret);
	end

	idle_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !timing.hsync && !timing.vsync && !timing.vblank
			&& !req_valid && !overflow)
	else $error("outputs not idle after reset release");

	credits_bounded: assert property (@(posedge clk) disable iff (reset)
		outstanding <= 4'(`VDC_FETCH_CREDITS))
	else $error("more requests outstanding than credits");

	issue_needs_credit: assert property (@(posedge clk) disable iff (reset)
		req_valid |-> outstanding < 4'(`VDC_FETCH_CREDITS))
	else $error("request issued with no credit left");

	overflow_sticky: assert property (@(posedge clk) disable iff (reset)
		overflow |=> overflow)
	else $error("overflow dropped without reset");

endmodule

bind vdc_timing_top vdc_timing_properties u_properties (
	.clk        (clk),
	.reset      (reset),
	.credit_ret (credit_ret),
	.timing     (timing),
	.req_valid  (req_valid),
	.overflow   (overflow)
);

// ==== sim/vdc_timing_tb.sv ====
`timescale 1ns/1ps
`include "vdc_macros.svh"

module vdc_timing_tb import vdc_pkg::*; ();

	logic        clk;
	logic        reset;
	logic        enable;
	logic        reg_we;
	logic [5:0]  reg_addr;
	logic [7:0]  reg_wdata;
	logic        credit_ret;
	logic [7:0]  reg_rdata;
	vdc_timing_t timing;
	logic        req_valid;
	fetch_req_t  req;
	logic        overflow;

	logic [31:0] lfsr = 32'he80d0ca5;
	logic        bit_a;
	logic        bit_b;
	logic        allow_credit = 1'b1;
	int          outstanding = 0; // requests taken and not yet credited
	int          pending_out;
	logic        hs_prev = 1'b0;
	logic        vs_prev = 1'b0;
	logic        have_rise = 1'b0;
	logic        track_frames = 1'b0; // frame requests mark the measurement window
	logic        check_on = 1'b0;
	int          en_cycles = 0; // enabled cycles since the last hsync rise
	int          hs_width = 0;
	int          hs_in_frame = 0;
	int          hs_in_vsync = 0;
	int          disp_cycles = 0; // enabled cycles with display high in this frame
	int          frame_seen = 0;
	int          tries;

	vdc_timing_top DUT (
		.clk        (clk),
		.reset      (reset),
		.enable     (enable),
		.reg_we     (reg_we),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.credit_ret (credit_ret),
		.reg_rdata  (reg_rdata),
		.timing     (timing),
		.req_valid  (req_valid),
		.req        (req),
		.overflow   (overflow)
	);

	always #50 clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic report_failure();
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input int expected, input int actual);
		$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
		report_failure();
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out waiting for %s", what);
		report_failure();
	endtask

	task automatic write_reg(input logic [5:0] addr, input logic [7:0] data);
		@(posedge clk);
		reg_we <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		@(posedge clk);
		reg_we <= 1'b0;
	endtask

	task automatic check_reg(input logic [5:0] addr, input logic [7:0] expected);
		@(posedge clk);
		reg_addr <= addr;
		@(posedge clk);
		assert (reg_rdata == expected)
		else fail_value($sformatf("readback_r%0d", addr), expected, reg_rdata);
	endtask

	task automatic wait_frames(input int count);
		tries = 0;
		while (frame_seen < count) begin
			@(posedge clk);
			tries++;
			if (tries > 5000)
				fail_timeout("a frame request");
		end
	endtask

	// enable about 3 of 4 cycles, credits back at random while any are out
	always @(posedge clk) begin
		lfsr = lfsr_step(lfsr);
		bit_a = lfsr[0];
		lfsr = lfsr_step(lfsr);
		bit_b = lfsr[0];
		enable <= !(bit_a && bit_b);
		lfsr = lfsr_step(lfsr);
		pending_out = outstanding + (req_valid ? 1 : 0) - (credit_ret ? 1 : 0);
		outstanding = pending_out;
		credit_ret <= allow_credit && !reset && pending_out > 0 && lfsr[0];
	end

	// horizontal and vertical measurements
	always @(posedge clk) begin
		if (timing.hsync && !hs_prev) begin
			if (check_on && have_rise) begin
				assert (en_cycles == 16)
				else fail_value("hsync_period", 16, en_cycles);
			end
			have_rise = 1'b1;
			en_cycles = 0;
			hs_width = 0;
			hs_in_frame++;
			if (timing.vsync)
				hs_in_vsync++;
		end
		if (!timing.hsync && hs_prev && check_on) begin
			assert (hs_width == 2)
			else fail_value("hsync_width", 2, hs_width);
		end
		if (timing.vsync && !vs_prev)
			hs_in_vsync = 0;
		if (!timing.vsync && vs_prev && check_on) begin
			assert (hs_in_vsync == 3)
			else fail_value("vsync_width", 3, hs_in_vsync);
		end
		if (req_valid && req.kind == FETCH_FRAME && track_frames) begin
			if (check_on) begin
				assert (hs_in_frame == 24)
				else fail_value("frame_lines", 24, hs_in_frame);
				assert (disp_cycles == 160)
				else fail_value("display_cycles", 160, disp_cycles); // hd * vd * (ctv + 1)
			end
			check_on = 1'b1;
			hs_in_frame = 0;
			disp_cycles = 0;
			frame_seen++;
		end
		if (check_on) begin
			assert (!timing.frame)
			else fail_value("field_bit", 0, timing.frame); // one field when not interlaced
		end
		if (enable)
			en_cycles++;
		if (timing.hsync && enable)
			hs_width++;
		if (timing.display && enable)
			disp_cycles++;
		hs_prev = timing.hsync;
		vs_prev = timing.vsync;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		reg_we = 1'b0;
		reg_addr = 6'd0;
		reg_wdata = 8'd0;
		credit_ret = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		@(posedge clk);
		assert (!timing.hsync && !timing.vsync && !timing.vblank && !req_valid && !overflow)
		else fail_value("reset_idle", 0, {timing.hsync, timing.vsync, timing.vblank,
			req_valid, overflow});

		write_reg(6'd0, 8'd15);
		write_reg(6'd1, 8'd10);
		write_reg(6'd2, 8'd12);
		write_reg(6'd3, 8'h32); // vw 3, hw 2
		write_reg(6'd4, 8'd5);
		write_reg(6'd5, 8'd0);
		write_reg(6'd6, 8'd4);
		write_reg(6'd7, 8'd4);
		write_reg(6'd8, 8'd0);
		write_reg(6'd9, 8'd3);
		write_reg(6'd24, 8'd0);
		check_reg(6'd0, 8'd15);
		check_reg(6'd1, 8'd10);
		check_reg(6'd2, 8'd12);
		check_reg(6'd3, 8'h32);
		check_reg(6'd4, 8'd5);
		check_reg(6'd5, 8'd0);
		check_reg(6'd6, 8'd4);
		check_reg(6'd7, 8'd4);
		check_reg(6'd8, 8'd0);
		check_reg(6'd9, 8'd3);
		check_reg(6'd24, 8'd0);
		check_reg(6'd12, 8'd0); // unmapped
		track_frames = 1'b1;

		wait_frames(3);

		// hold back credits until a request is lost
		track_frames = 1'b0; // frame requests stall from here on
		allow_credit = 1'b0;
		tries = 0;
		while (!overflow) begin
			@(posedge clk);
			tries++;
			if (tries > 5000)
				fail_timeout("overflow under back-pressure");
		end
		allow_credit = 1'b1;
		tries = 0;
		do begin
			@(posedge clk);
			tries++;
			if (tries > 200)
				fail_timeout("a returned credit");
		end while (!credit_ret);
		@(posedge clk);
		@(posedge clk);
		assert (req_valid)
		else fail_value("held_request_issue", 1, req_valid); // slot takes the first credit
		repeat (20) @(posedge clk);
		assert (overflow)
		else fail_value("overflow_sticky", 1, overflow);

		$display("*** PASSED ***");
		$finish;
	end

endmodule
